//--- include/cmul_consts.svh
`ifndef CMUL_CONSTS_SVH
`define CMUL_CONSTS_SVH

// pipeline depths in clock cycles
`define CMUL_MULT_LATENCY 8
`define CMUL_ADD_LATENCY  11
`define CMUL_LATENCY      (`CMUL_MULT_LATENCY + `CMUL_ADD_LATENCY)

// mantissa product register chain
`define CMUL_PROD_STAGES  6

// fp32 encoding
`define FP32_EXP_MAX      8'hff
`define FP32_BIAS         127
`define FP32_SIGN_BIT     31

`endif

//--- design/fp32_pkg.sv
`default_nettype none

package fp32_pkg;

  // ieee single word
  typedef logic [31:0] fp32_t;

  // biased exponent, and one bit wider for carry or borrow
  typedef logic [7:0]  exp_t;
  typedef logic [8:0]  wide_exp_t;

  // significand including hidden bit
  typedef logic [23:0] mant_t;

  typedef struct packed {
    fp32_t re;
    fp32_t im;
  } complex_t;

endpackage

`default_nettype wire

//--- design/fp32_mult.sv
`timescale 1ns/100ps
`default_nettype none

`include "cmul_consts.svh"

module fp32_mult (
  input  logic            clk,
  input  fp32_pkg::fp32_t a,
  input  fp32_pkg::fp32_t b,
  output fp32_pkg::fp32_t p
);

  typedef struct packed {
    logic                sign;
    logic                zero;
    logic                inf;
    logic                nan;
    fp32_pkg::wide_exp_t exp;
  } mult_ctl_t;

  fp32_pkg::exp_t      exp_a;
  fp32_pkg::exp_t      exp_b;
  fp32_pkg::mant_t     sig_a;
  fp32_pkg::mant_t     sig_b;
  logic [47:0]         prod_q [`CMUL_PROD_STAGES];
  logic [47:0]         prod;
  logic                nan_a_s1;
  logic                nan_b_s1;
  logic                inf_a_s1;
  logic                inf_b_s1;
  logic                zero_a_s1;
  logic                zero_b_s1;
  logic                sign_s1;
  fp32_pkg::wide_exp_t exp_s1;
  logic                under_s2;
  mult_ctl_t           ctl_s2;
  mult_ctl_t           ctl_s3;
  mult_ctl_t           ctl_s4;
  mult_ctl_t           ctl_s5;
  mult_ctl_t           ctl_s6;
  mult_ctl_t           ctl_s7;
  logic [22:0]         frac_s7;

  assign exp_a = a[30:23];
  assign exp_b = b[30:23];
  assign sig_a = {1'b1, a[22:0]};
  assign sig_b = {1'b1, b[22:0]};

  // significand product, folded into a plain register chain
  always_ff @(posedge clk) begin
    prod_q[0] <= sig_a * sig_b;
    for (int i = 1; i < `CMUL_PROD_STAGES; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
  end

  assign prod = prod_q[`CMUL_PROD_STAGES-1];

  // stage 1: decode specials, sum exponents
  always_ff @(posedge clk) begin
    nan_a_s1  <= (exp_a == `FP32_EXP_MAX) && (a[22:0] != '0);
    nan_b_s1  <= (exp_b == `FP32_EXP_MAX) && (b[22:0] != '0);
    inf_a_s1  <= (exp_a == `FP32_EXP_MAX) && (a[22:0] == '0);
    inf_b_s1  <= (exp_b == `FP32_EXP_MAX) && (b[22:0] == '0);
    zero_a_s1 <= (exp_a == 8'h00);
    zero_b_s1 <= (exp_b == 8'h00);
    sign_s1   <= a[`FP32_SIGN_BIT] ^ b[`FP32_SIGN_BIT];
    exp_s1    <= {1'b0, exp_a} + {1'b0, exp_b};
  end

  // stage 2: remove bias
  always_ff @(posedge clk) begin
    ctl_s2.sign <= sign_s1;
    ctl_s2.zero <= zero_a_s1 | zero_b_s1;
    ctl_s2.inf  <= inf_a_s1 | inf_b_s1;
    ctl_s2.nan  <= nan_a_s1 | nan_b_s1;
    ctl_s2.exp  <= exp_s1 - fp32_pkg::wide_exp_t'(`FP32_BIAS);
    under_s2    <= exp_s1 < fp32_pkg::wide_exp_t'(`FP32_BIAS + 1);
  end

  // stage 3: underflow flushes, 0 * inf is nan
  always_ff @(posedge clk) begin
    ctl_s3      <= ctl_s2;
    ctl_s3.zero <= ctl_s2.zero | under_s2;
    ctl_s3.inf  <= ctl_s2.inf | (ctl_s2.exp[8] & ~under_s2);
    ctl_s3.nan  <= ctl_s2.nan | (ctl_s2.zero & ctl_s2.inf);
  end

  // stage 4
  always_ff @(posedge clk) begin
    ctl_s4     <= ctl_s3;
    ctl_s4.inf <= ctl_s3.inf | (ctl_s3.exp == {1'b0, `FP32_EXP_MAX});
  end

  // stages 5 and 6 wait for the product
  always_ff @(posedge clk) begin
    ctl_s5 <= ctl_s4;
    ctl_s6 <= ctl_s5;
  end

  // stage 7: one-bit normalize
  always_ff @(posedge clk) begin
    ctl_s7 <= ctl_s6;
    if (prod[47]) begin
      ctl_s7.exp <= ctl_s6.exp + 9'd1;
      ctl_s7.inf <= ctl_s6.inf | (ctl_s6.exp == {1'b0, `FP32_EXP_MAX} - 9'd1);
      frac_s7    <= prod[46:24];
    end else begin
      frac_s7    <= prod[45:23];
    end
  end

  // stage 8: force special encodings
  always_ff @(posedge clk) begin
    p[`FP32_SIGN_BIT] <= ctl_s7.sign;
    if (ctl_s7.inf || ctl_s7.nan) begin
      p[30:23] <= `FP32_EXP_MAX;
    end else if (ctl_s7.zero) begin
      p[30:23] <= 8'h00;
    end else begin
      p[30:23] <= ctl_s7.exp[7:0];
    end
    if (ctl_s7.nan) begin
      p[22:0] <= 23'd1;
    end else if (ctl_s7.zero || ctl_s7.inf) begin
      p[22:0] <= '0;
    end else begin
      p[22:0] <= frac_s7;
    end
  end

  // max exponent only comes from a flagged result
  assert property (@(posedge clk)
    (p[30:23] == `FP32_EXP_MAX) |-> $past(ctl_s7.inf || ctl_s7.nan))
    else $error("fp32_mult: unflagged all-ones exponent");

endmodule

`default_nettype wire

//--- design/fp32_add.sv
`timescale 1ns/100ps
`default_nettype none

`include "cmul_consts.svh"

module fp32_add (
  input  logic            clk,
  input  fp32_pkg::fp32_t a,
  input  fp32_pkg::fp32_t b,
  output fp32_pkg::fp32_t s
);

  typedef struct packed {
    logic            sign;
    fp32_pkg::exp_t  exp;
    fp32_pkg::mant_t big;
    fp32_pkg::mant_t lesser;
    logic            add;
  } align_t;

  typedef struct packed {
    logic                sign;
    fp32_pkg::wide_exp_t exp;
    fp32_pkg::mant_t     sig;
    logic                of;
  } norm_t;

  function automatic norm_t shift_left(input norm_t x, input logic [3:0] n);
    norm_t y;
    y     = x;
    y.sig = x.sig << n;
    y.exp = x.exp - fp32_pkg::wide_exp_t'(n);
    return y;
  endfunction

  fp32_pkg::exp_t      exp_a;
  fp32_pkg::exp_t      exp_b;
  logic                a_is_big;
  fp32_pkg::fp32_t     big_s1;
  fp32_pkg::fp32_t     small_s1;
  fp32_pkg::exp_t      diff_s1;
  fp32_pkg::mant_t     sig_big;
  fp32_pkg::mant_t     sig_small;
  align_t              al_s2;
  align_t              al_s3;
  align_t              al_s4;
  logic [3:0]          diff_s2;
  logic [1:0]          diff_s3;
  logic                sign_s5;
  fp32_pkg::wide_exp_t exp_s5;
  logic [24:0]         sum_s5;
  logic                of_s5;
  norm_t               nrm_s6;
  norm_t               nrm_s7;
  norm_t               nrm_s8;
  norm_t               nrm_s9;
  norm_t               nrm_s10;

  assign exp_a    = a[30:23];
  assign exp_b    = b[30:23];
  assign a_is_big = (exp_a > exp_b) || ((exp_a == exp_b) && (a[22:0] >= b[22:0]));

  // stage 1 orders by magnitude
  always_ff @(posedge clk) begin
    big_s1   <= a_is_big ? a : b;
    small_s1 <= a_is_big ? b : a;
    diff_s1  <= a_is_big ? exp_a - exp_b : exp_b - exp_a;
  end

  // exponent 0 counts as zero and gaps of 32 or more lose the small operand
  assign sig_big   = (big_s1[30:23] != 8'h00) ? {1'b1, big_s1[22:0]} : '0;
  assign sig_small = ((diff_s1[7:5] != 3'b000) || (small_s1[30:23] == 8'h00)) ? '0 :
                     ({1'b1, small_s1[22:0]} >> {diff_s1[4], 4'b0000});

  // stage 2 does the coarse align
  always_ff @(posedge clk) begin
    al_s2.sign   <= big_s1[`FP32_SIGN_BIT];
    al_s2.exp    <= big_s1[30:23];
    al_s2.big    <= sig_big;
    al_s2.lesser <= sig_small;
    al_s2.add    <= big_s1[`FP32_SIGN_BIT] == small_s1[`FP32_SIGN_BIT];
    diff_s2      <= diff_s1[3:0];
  end

  // stages 3 and 4 shift by 4, 8 or 12 and then by 1, 2 or 3
  always_ff @(posedge clk) begin
    al_s3        <= al_s2;
    al_s3.lesser <= al_s2.lesser >> {diff_s2[3:2], 2'b00};
    diff_s3      <= diff_s2[1:0];
    al_s4        <= al_s3;
    al_s4.lesser <= al_s3.lesser >> diff_s3;
  end

  // stage 5 adds or subtracts
  always_ff @(posedge clk) begin
    sign_s5 <= al_s4.sign;
    exp_s5  <= {1'b0, al_s4.exp};
    of_s5   <= al_s4.exp == `FP32_EXP_MAX;
    if (al_s4.add) begin
      sum_s5 <= {1'b0, al_s4.big} + {1'b0, al_s4.lesser};
    end else begin
      sum_s5 <= {1'b0, al_s4.big} - {1'b0, al_s4.lesser};
    end
  end

  // stage 6 moves a carry out one bit right
  always_ff @(posedge clk) begin
    nrm_s6.sign <= sign_s5;
    if (sum_s5[24] && !of_s5) begin
      nrm_s6.exp <= exp_s5 + 9'd1;
      nrm_s6.sig <= sum_s5[24:1];
      nrm_s6.of  <= exp_s5 == {1'b0, `FP32_EXP_MAX} - 9'd1;
    end else begin
      nrm_s6.exp <= exp_s5;
      nrm_s6.sig <= sum_s5[23:0];
      nrm_s6.of  <= of_s5;
    end
  end

  // stages 7 to 10 strip leading zeros after a subtract
  always_ff @(posedge clk) begin
    nrm_s7 <= (nrm_s6.sig[23:16] == 8'h00) ? shift_left(nrm_s6, 4'd8) : nrm_s6;
    nrm_s8 <= (nrm_s7.sig[23:16] == 8'h00) ? shift_left(nrm_s7, 4'd8) : nrm_s7;
    nrm_s9 <= (nrm_s8.sig[23:20] == 4'h0) ? shift_left(nrm_s8, 4'd4) : nrm_s8;
    if (nrm_s9.sig[23:20] == 4'h0) begin
      nrm_s10 <= shift_left(nrm_s9, 4'd4);
    end else if (nrm_s9.sig[23:21] == 3'b000) begin
      nrm_s10 <= shift_left(nrm_s9, 4'd3);
    end else if (nrm_s9.sig[23:22] == 2'b00) begin
      nrm_s10 <= shift_left(nrm_s9, 4'd2);
    end else if (!nrm_s9.sig[23]) begin
      nrm_s10 <= shift_left(nrm_s9, 4'd1);
    end else begin
      nrm_s10 <= nrm_s9;
    end
  end

  // stage 11 clamps overflow and underflow
  always_ff @(posedge clk) begin
    s[`FP32_SIGN_BIT] <= nrm_s10.sign;
    if (nrm_s10.of) begin
      s[30:0] <= {`FP32_EXP_MAX, 23'd0};
    end else if (nrm_s10.exp[8] || (nrm_s10.exp == '0) || (nrm_s10.sig == '0)) begin
      s[30:0] <= '0;
    end else begin
      s[30:0] <= {nrm_s10.exp[7:0], nrm_s10.sig[22:0]};
    end
  end

  // aligned small significand never exceeds the big one
  assert property (@(posedge clk) al_s4.big >= al_s4.lesser)
    else $error("fp32_add: aligned small operand larger than big operand");

endmodule

`default_nettype wire

//--- design/strobe_delay.sv
`timescale 1ns/100ps
`default_nettype none

module strobe_delay #(
  parameter int DEPTH = 1
) (
  input  logic clk,
  input  logic reset,
  input  logic strobe_in,
  output logic strobe_out
);

  logic [DEPTH-1:0] chain_q;
  logic [DEPTH-1:0] reset_hist_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      chain_q <= '0;
    end else begin
      chain_q[0] <= strobe_in;
      for (int i = 1; i < DEPTH; i++) begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  assign strobe_out = chain_q[DEPTH-1];

  // resets seen over the last DEPTH edges
  always_ff @(posedge clk) begin
    reset_hist_q[0] <= reset;
    for (int i = 1; i < DEPTH; i++) begin
      reset_hist_q[i] <= reset_hist_q[i-1];
    end
  end

  assert property (@(posedge clk)
    (reset_hist_q == '0) |-> (strobe_out == $past(strobe_in, DEPTH)))
    else $error("strobe_delay: output out of step with input");

endmodule

`default_nettype wire

//--- design/complex_mult.sv
`timescale 1ns/100ps
`default_nettype none

`include "cmul_consts.svh"

module complex_mult (
  input  logic               clk,
  input  logic               reset,
  input  fp32_pkg::complex_t in0,
  input  fp32_pkg::complex_t in1,
  input  logic               next,
  output fp32_pkg::complex_t out,
  output logic               next_out
);

  fp32_pkg::fp32_t rr;
  fp32_pkg::fp32_t ii;
  fp32_pkg::fp32_t ri;
  fp32_pkg::fp32_t ir;
  fp32_pkg::fp32_t ii_neg;

  // four partial products
  fp32_mult mult_rr (.clk(clk), .a(in0.re), .b(in1.re), .p(rr));
  fp32_mult mult_ii (.clk(clk), .a(in0.im), .b(in1.im), .p(ii));
  fp32_mult mult_ri (.clk(clk), .a(in0.re), .b(in1.im), .p(ri));
  fp32_mult mult_ir (.clk(clk), .a(in0.im), .b(in1.re), .p(ir));

  // re = rr - ii
  assign ii_neg = {~ii[`FP32_SIGN_BIT], ii[`FP32_SIGN_BIT-1:0]};

  fp32_add add_re (.clk(clk), .a(rr), .b(ii_neg), .s(out.re));
  fp32_add add_im (.clk(clk), .a(ri), .b(ir), .s(out.im));

  // strobe follows the datapath
  strobe_delay #(
    .DEPTH (`CMUL_LATENCY)
  ) next_dly (
    .clk        (clk),
    .reset      (reset),
    .strobe_in  (next),
    .strobe_out (next_out)
  );

endmodule

`default_nettype wire

//--- verification/complex_mult_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cmul_consts.svh"

module complex_mult_tb;

  localparam int    PERIOD       = 40;
  localparam int    RESET_CYCLES = 16;
  localparam int    MAX_GAP      = 3;
  localparam int    MARGIN       = 32;
  localparam string VECTOR_FILE  = "verification/complex_mult_vectors.txt";

  typedef struct packed {
    logic [7:0]         test;
    fp32_pkg::complex_t a;
    fp32_pkg::complex_t b;
    fp32_pkg::complex_t result;
  } vector_t;

  // one entry per issued vector with the oldest first
  typedef struct packed {
    logic [7:0]         test;
    fp32_pkg::complex_t result;
    logic [31:0]        issue;
  } pending_t;

  logic               clk;
  logic               reset;
  fp32_pkg::complex_t in0;
  fp32_pkg::complex_t in1;
  logic               next;
  fp32_pkg::complex_t out;
  logic               next_out;

  vector_t            vectors[$];
  pending_t           expect_q[$];
  integer             seed;
  int unsigned        edge_count = 0;
  int unsigned        passed = 0;
  int unsigned        errors = 0;
  logic               loaded = 1'b0;

  complex_mult dut_i (
    .clk      (clk),
    .reset    (reset),
    .in0      (in0),
    .in1      (in1),
    .next     (next),
    .out      (out),
    .next_out (next_out)
  );

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  always @(posedge clk) edge_count <= edge_count + 1;

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  t;
    logic [31:0] ar;
    logic [31:0] ai;
    logic [31:0] br;
    logic [31:0] bi;
    logic [31:0] er;
    logic [31:0] ei;
    vector_t     v;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h", t, ar, ai, br, bi, er, ei);
        // header and blank lines do not scan
        if (n == 7) begin
          v.test      = t;
          v.a.re      = ar;
          v.a.im      = ai;
          v.b.re      = br;
          v.b.im      = bi;
          v.result.re = er;
          v.result.im = ei;
          vectors.push_back(v);
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic int pick_gap();
    if ($random(seed) & 1) begin
      return 0;
    end
    return $random(seed) & MAX_GAP;
  endfunction

  // random operands with the strobe held low
  task automatic drive_idle(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      in0  <= {$random(seed), $random(seed)};
      in1  <= {$random(seed), $random(seed)};
      next <= 1'b0;
    end
  endtask

  task automatic drive_vector(input vector_t v);
    pending_t p;
    @(posedge clk);
    in0      <= v.a;
    in1      <= v.b;
    next     <= 1'b1;
    p.test   = v.test;
    p.result = v.result;
    // edge count once this edge has been counted
    p.issue  = edge_count + 1;
    expect_q.push_back(p);
  endtask

  task automatic check_result(input pending_t p);
    int unsigned latency;
    logic        ok;
    latency = edge_count - p.issue;
    ok = 1'b1;
    assert (latency == `CMUL_LATENCY)
      else begin
        $display("FAILED at %0t: test %02h came out after %0d cycles, expected %0d",
                 $time, p.test, latency, `CMUL_LATENCY);
        ok = 1'b0;
      end
    assert (out === p.result)
      else begin
        $display("FAILED at %0t: test %02h out re %h im %h, expected re %h im %h",
                 $time, p.test, out.re, out.im, p.result.re, p.result.im);
        ok = 1'b0;
      end
    if (ok) begin
      passed++;
      $display("test %02h ok: re %h im %h", p.test, out.re, out.im);
    end else begin
      errors++;
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (next_out === 1'b1) begin
      if (expect_q.size() == 0) begin
        $display("next_out went high at %0t with no vector outstanding", $time);
        errors++;
      end else begin
        check_result(expect_q.pop_front());
      end
    end else if (next_out !== 1'b0 && edge_count > 1) begin
      $display("next_out is unknown at %0t", $time);
      errors++;
    end
  end

  initial begin
    reset = 1'b1;
    next  = 1'b0;
    in0   = '0;
    in1   = '0;
    seed  = 32'hcc3c_3e8d;
    load_vectors();
    loaded = 1'b1;
    if (vectors.size() == 0) begin
      $display("no vectors could be read from %s", VECTOR_FILE);
      $display("=== FAIL ===");
      $finish;
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      foreach (vectors[k]) begin
        drive_idle(pick_gap());
        drive_vector(vectors[k]);
      end
      drive_idle(1);
      while (expect_q.size() != 0) @(negedge clk);
      // a few more cycles to catch a stray next_out
      repeat (4) @(negedge clk);
      $display("%0d tests, %0d passed, %0d errors", vectors.size(), passed, errors);
      if (errors == 0 && passed == vectors.size()) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

  // longest run is every vector behind a full gap
  initial begin
    int unsigned limit;
    wait (loaded);
    limit = RESET_CYCLES + vectors.size() * (MAX_GAP + 1) + `CMUL_LATENCY + MARGIN;
    #(limit * PERIOD);
    $display("timeout: %0d results never came out of the DUT", expect_q.size());
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- complex_mult.f
+incdir+include
design/fp32_pkg.sv
design/fp32_mult.sv
design/fp32_add.sv
design/strobe_delay.sv
design/complex_mult.sv
verification/complex_mult_tb.sv

//--- run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module complex_mult_tb -f complex_mult.f -o complex_mult_sim \
  && ./obj_dir/complex_mult_sim | tee sim.log \
  || { echo "build or simulation did not complete"; exit 1; }

grep -qx "=== PASS ===" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- verification/complex_mult_vectors.txt
# test in0.re in0.im in1.re in1.im out.re out.im
# all fields hex, values exactly representable
01 40400000 40000000 3f800000 40800000 c0a00000 41600000
02 3f000000 bfc00000 40000000 40000000 40800000 c0000000
03 3f800000 3f800000 3f800000 3f800000 00000000 40000000
04 40000000 40400000 40800000 40a00000 c0e00000 41b00000
05 00000000 00000000 40400000 40000000 00000000 00000000
06 c0000000 c0400000 00000000 00000000 80000000 80000000
07 00400000 3f800000 40000000 40400000 c0400000 40000000
08 71800000 00000000 71800000 00000000 7f800000 00000000
09 5f800000 5f800000 5f800000 00000000 7f800000 7f800000
0a 7f800000 3f800000 40000000 3f800000 7f800000 7f800000
0b 3f800000 bf800000 ff800000 3f800000 ff800000 7f800000
0c 3e800000 3f400000 41000000 c0800000 40a00000 40a00000
0d 3fc00000 bfc00000 3fc00000 3fc00000 40900000 00000000
0e 47800000 3f800000 3f800000 3f800000 477fff00 47800080
0f c0400000 c0000000 bf800000 40800000 41300000 c1200000
10 40a00000 00000000 40e00000 00000000 420c0000 00000000
11 00000000 3f800000 00000000 3f800000 bf800000 00000000
12 0d800000 00000000 0d800000 00000000 00000000 00000000
13 41200000 41400000 3f000000 3e800000 40000000 41080000
